//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cartridge_tb
FILELIST = compile.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
design/cart_pkg.sv
design/rtc_pkg.sv
design/mbc_registers.sv
design/rtc_counter.sv
design/save_sequencer.sv
design/ext_ram.sv
design/cart_read_mux.sv
design/cartridge_top.sv
verif/tb_clock_gen.sv
verif/cartridge_tb.sv

//--- design/cart_pkg.sv
`default_nettype none

package cart_pkg;

   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  cpu_data_t;
   typedef logic [23:0] flash_addr_t;   // word address into the flash
   typedef logic [15:0] flash_data_t;
   typedef logic [6:0]  rom_bank_t;
   typedef logic [3:0]  ram_bank_t;     // ram bank 0-3 or clock register 8-12
   typedef logic [14:0] ram_addr_t;     // 4 banks of 8 KB

   // cpu memory map
   localparam cpu_addr_t rom_end         = 16'h8000;
   localparam cpu_addr_t ram_window_base = 16'hA000;
   localparam cpu_addr_t ram_window_end  = 16'hC000;

   localparam cpu_data_t ram_enable_key = 8'h0A;

   // save image lives here in flash
   localparam flash_addr_t save_flash_base = 24'h200000;
   localparam int ram_bytes = 32768;

   typedef enum logic [2:0] {
      idle,
      write_addr,      // present ram address, ram data arrives next cycle
      write_strobe,
      load_addr,
      load_capture
   } save_state_t;

endpackage

`default_nettype wire

//--- design/cart_read_mux.sv
`default_nettype none

module cart_read_mux (
   input  wire cart_pkg::cpu_addr_t   cpu_addr,
   input  wire cart_pkg::cpu_data_t   cpu_data_in,
   input  wire                    cpu_we_n,
   input  wire                    cpu_re_n,
   input  wire                    ram_enable,
   input  wire cart_pkg::rom_bank_t   rom_bank,
   input  wire cart_pkg::ram_bank_t   ram_bank,
   input  wire rtc_pkg::rtc_byte_t    rtc_read_byte,
   input  wire                    copy_active,
   input  wire cart_pkg::ram_addr_t   copy_index,
   input  wire                    copy_write,
   input  wire cart_pkg::flash_addr_t flash_addr_save,
   input  wire                    flash_oe_n,
   input  wire cart_pkg::flash_data_t flash_data_in,
   input  wire cart_pkg::cpu_data_t   ram_rdata,
   output cart_pkg::ram_addr_t    ram_addr,
   output logic                   ram_we,
   output cart_pkg::cpu_data_t    ram_wdata,
   output cart_pkg::flash_addr_t  flash_addr,
   output cart_pkg::flash_data_t  flash_data_out,
   output logic                   flash_data_oe,
   output cart_pkg::cpu_data_t    cpu_data_out,
   output logic                   cpu_data_oe
);

   logic                  in_rom, in_window, ram_bank_sel;
   cart_pkg::cpu_addr_t   window_offset;
   cart_pkg::flash_addr_t rom_addr;

   assign in_rom        = (cpu_addr < cart_pkg::rom_end);
   assign in_window     = (cpu_addr >= cart_pkg::ram_window_base)
                          && (cpu_addr < cart_pkg::ram_window_end);
   assign ram_bank_sel  = (ram_bank[3:2] == 2'b00);   // banks 0-3 are real ram
   assign window_offset = cpu_addr - cart_pkg::ram_window_base;

   // banks laid out back to back in flash, 16 KB each
   assign rom_addr = cpu_addr[14] ? {3'd0, rom_bank, cpu_addr[13:0]}
                                  : {10'd0, cpu_addr[13:0]};
   assign flash_addr = copy_active ? flash_addr_save : rom_addr;

   assign ram_addr  = copy_active ? copy_index : {ram_bank[1:0], window_offset[12:0]};
   assign ram_we    = copy_active ? copy_write
                                  : (!cpu_we_n && ram_enable && in_window && ram_bank_sel);
   assign ram_wdata = copy_active ? flash_data_in[7:0] : cpu_data_in;

   assign flash_data_out = {8'h00, ram_rdata};
   assign flash_data_oe  = copy_active && flash_oe_n;   // save direction only

   always_comb begin
      if (in_rom) begin
         cpu_data_out = flash_data_in[7:0];
      end else if (in_window && ram_enable) begin
         cpu_data_out = ram_bank_sel ? ram_rdata : rtc_read_byte;   // rtc gives 0 off range
      end else begin
         cpu_data_out = '0;
      end
   end

   assign cpu_data_oe = !cpu_re_n;

endmodule

`default_nettype wire

//--- design/cartridge_top.sv
`default_nettype none

module cartridge_top #(
   parameter int ticks_per_second = 33_000_000
) (
   input  wire                    I_CLK_33MHZ,
   input  wire                    I_RESET,
   input  wire cart_pkg::cpu_addr_t   cpu_addr,
   input  wire cart_pkg::cpu_data_t   cpu_data_in,
   input  wire                    cpu_we_n,
   input  wire                    cpu_re_n,
   output cart_pkg::cpu_data_t    cpu_data_out,
   output logic                   cpu_data_oe,
   output cart_pkg::flash_addr_t  flash_addr,
   input  wire cart_pkg::flash_data_t flash_data_in,
   output cart_pkg::flash_data_t  flash_data_out,
   output logic                   flash_data_oe,
   output logic                   flash_oe_n,
   output logic                   flash_we_n,
   input  wire                    save,
   input  wire                    load,
   output logic                   halt
);

   logic                  ram_enable, latch_clock;
   cart_pkg::rom_bank_t   rom_bank;
   cart_pkg::ram_bank_t   ram_bank;
   rtc_pkg::rtc_byte_t    rtc_read_byte;
   logic                  copy_active, copy_write;
   cart_pkg::ram_addr_t   copy_index, ram_addr;
   cart_pkg::flash_addr_t flash_addr_save;
   logic                  ram_we;
   cart_pkg::cpu_data_t   ram_wdata, ram_rdata;

   mbc_registers u_mbc_registers (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .cpu_addr    (cpu_addr),
      .cpu_data_in (cpu_data_in),
      .cpu_we_n    (cpu_we_n),
      .ram_enable  (ram_enable),
      .rom_bank    (rom_bank),
      .ram_bank    (ram_bank),
      .latch_clock (latch_clock)
   );

   rtc_counter #(
      .ticks_per_second (ticks_per_second)
   ) u_rtc_counter (
      .I_CLK_33MHZ   (I_CLK_33MHZ),
      .I_RESET       (I_RESET),
      .cpu_addr      (cpu_addr),
      .cpu_data_in   (cpu_data_in),
      .cpu_we_n      (cpu_we_n),
      .ram_enable    (ram_enable),
      .ram_bank      (ram_bank),
      .latch_clock   (latch_clock),
      .rtc_read_byte (rtc_read_byte)
   );

   save_sequencer u_save_sequencer (
      .I_CLK_33MHZ     (I_CLK_33MHZ),
      .I_RESET         (I_RESET),
      .save            (save),
      .load            (load),
      .copy_active     (copy_active),
      .copy_index      (copy_index),
      .copy_write      (copy_write),
      .flash_addr_save (flash_addr_save),
      .flash_oe_n      (flash_oe_n),
      .flash_we_n      (flash_we_n),
      .halt            (halt)
   );

   ext_ram u_ext_ram (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .ram_we      (ram_we),
      .ram_addr    (ram_addr),
      .ram_wdata   (ram_wdata),
      .ram_rdata   (ram_rdata)
   );

   cart_read_mux u_cart_read_mux (
      .cpu_addr        (cpu_addr),
      .cpu_data_in     (cpu_data_in),
      .cpu_we_n        (cpu_we_n),
      .cpu_re_n        (cpu_re_n),
      .ram_enable      (ram_enable),
      .rom_bank        (rom_bank),
      .ram_bank        (ram_bank),
      .rtc_read_byte   (rtc_read_byte),
      .copy_active     (copy_active),
      .copy_index      (copy_index),
      .copy_write      (copy_write),
      .flash_addr_save (flash_addr_save),
      .flash_oe_n      (flash_oe_n),
      .flash_data_in   (flash_data_in),
      .ram_rdata       (ram_rdata),
      .ram_addr        (ram_addr),
      .ram_we          (ram_we),
      .ram_wdata       (ram_wdata),
      .flash_addr      (flash_addr),
      .flash_data_out  (flash_data_out),
      .flash_data_oe   (flash_data_oe),
      .cpu_data_out    (cpu_data_out),
      .cpu_data_oe     (cpu_data_oe)
   );

endmodule

`default_nettype wire

//--- design/ext_ram.sv
`default_nettype none

module ext_ram (
   input  wire                  I_CLK_33MHZ,
   input  wire                  ram_we,
   input  wire cart_pkg::ram_addr_t ram_addr,
   input  wire cart_pkg::cpu_data_t ram_wdata,
   output cart_pkg::cpu_data_t  ram_rdata
);

   cart_pkg::cpu_data_t mem [cart_pkg::ram_bytes];

   always_ff @(posedge I_CLK_33MHZ) begin
      if (ram_we) begin
         mem[ram_addr] <= ram_wdata;
      end
      ram_rdata <= mem[ram_addr];   // old data on a write cycle
   end

endmodule

`default_nettype wire

//--- design/mbc_registers.sv
`default_nettype none

module mbc_registers (
   input  wire                  I_CLK_33MHZ,
   input  wire                  I_RESET,
   input  wire cart_pkg::cpu_addr_t cpu_addr,
   input  wire cart_pkg::cpu_data_t cpu_data_in,
   input  wire                  cpu_we_n,
   output logic                 ram_enable,
   output cart_pkg::rom_bank_t  rom_bank,
   output cart_pkg::ram_bank_t  ram_bank,
   output logic                 latch_clock
);

   logic rom_write;
   logic zero_seen;   // last latch-range write was 0

   // control registers sit under the rom range
   assign rom_write = !cpu_we_n && (cpu_addr < cart_pkg::rom_end);

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         ram_enable  <= 1'b0;
         rom_bank    <= 7'd1;
         ram_bank    <= '0;
         zero_seen   <= 1'b0;
         latch_clock <= 1'b0;
      end else begin
         latch_clock <= 1'b0;   // single cycle pulse
         if (rom_write) begin
            case (cpu_addr[14:13])   // address 0x0000-0x7fff in 8 KB steps
               2'd0: begin
                  if (cpu_data_in == cart_pkg::ram_enable_key) begin
                     ram_enable <= 1'b1;
                  end else if (cpu_data_in == '0) begin
                     ram_enable <= 1'b0;
                  end
               end
               2'd1: begin
                  // bank 0 is already mapped low
                  if (cpu_data_in[6:0] == '0) begin
                     rom_bank <= 7'd1;
                  end else begin
                     rom_bank <= cpu_data_in[6:0];
                  end
               end
               2'd2: ram_bank <= cpu_data_in[3:0];
               default: begin
                  zero_seen   <= (cpu_data_in == '0);
                  latch_clock <= zero_seen && (cpu_data_in == 8'd1);
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

//--- design/rtc_counter.sv
`default_nettype none

module rtc_counter #(
   parameter int ticks_per_second = 33_000_000
) (
   input  wire                  I_CLK_33MHZ,
   input  wire                  I_RESET,
   input  wire cart_pkg::cpu_addr_t cpu_addr,
   input  wire cart_pkg::cpu_data_t cpu_data_in,
   input  wire                  cpu_we_n,
   input  wire                  ram_enable,
   input  wire cart_pkg::ram_bank_t ram_bank,
   input  wire                  latch_clock,
   output rtc_pkg::rtc_byte_t   rtc_read_byte
);

   logic [31:0]         prescale;
   logic                tick;
   logic                rtc_write;
   rtc_pkg::rtc_byte_t  seconds, minutes, hours;
   rtc_pkg::day_count_t days;
   logic                halted, carry;
   rtc_pkg::rtc_byte_t  lat_seconds, lat_minutes, lat_hours, lat_day_low, lat_day_high;

   function automatic rtc_pkg::rtc_byte_t day_high_byte(logic msb, logic h, logic c);
      rtc_pkg::rtc_byte_t b;
      b = '0;
      b[0] = msb;
      b[rtc_pkg::day_high_halt_bit]  = h;
      b[rtc_pkg::day_high_carry_bit] = c;
      return b;
   endfunction

   assign tick = !halted && (prescale == 32'(ticks_per_second - 1));
   assign rtc_write = !cpu_we_n && ram_enable && (cpu_addr >= cart_pkg::ram_window_base)
                      && (cpu_addr < cart_pkg::ram_window_end);

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         prescale     <= '0;
         {seconds, minutes, hours} <= '0;
         days         <= '0;
         halted       <= 1'b0;
         carry        <= 1'b0;
         {lat_seconds, lat_minutes, lat_hours} <= '0;
         {lat_day_low, lat_day_high} <= '0;
      end else begin
         if (!halted) begin
            prescale <= tick ? '0 : prescale + 1'b1;
         end
         if (tick) begin   // seconds -> minutes -> hours -> days -> carry
            seconds <= (seconds == 8'd59) ? '0 : seconds + 1'b1;
            if (seconds == 8'd59) begin
               minutes <= (minutes == 8'd59) ? '0 : minutes + 1'b1;
               if (minutes == 8'd59) begin
                  hours <= (hours == 8'd23) ? '0 : hours + 1'b1;
                  if (hours == 8'd23) begin
                     days <= days + 1'b1;   // wraps 511 -> 0
                     if (&days) begin
                        carry <= 1'b1;
                     end
                  end
               end
            end
         end
         if (latch_clock) begin
            lat_seconds  <= seconds;
            lat_minutes  <= minutes;
            lat_hours    <= hours;
            lat_day_low  <= days[7:0];
            lat_day_high <= day_high_byte(days[8], halted, carry);
         end
         // cpu writes load both the counter and its latched copy
         if (rtc_write) begin
            case (ram_bank)
               rtc_pkg::sel_seconds: begin
                  seconds     <= cpu_data_in;
                  lat_seconds <= cpu_data_in;
               end
               rtc_pkg::sel_minutes: begin
                  minutes     <= cpu_data_in;
                  lat_minutes <= cpu_data_in;
               end
               rtc_pkg::sel_hours: begin
                  hours     <= cpu_data_in;
                  lat_hours <= cpu_data_in;
               end
               rtc_pkg::sel_day_low: begin
                  days[7:0]   <= cpu_data_in;
                  lat_day_low <= cpu_data_in;
               end
               rtc_pkg::sel_day_high: begin
                  days[8] <= cpu_data_in[0];
                  halted  <= cpu_data_in[rtc_pkg::day_high_halt_bit];
                  carry   <= cpu_data_in[rtc_pkg::day_high_carry_bit];
                  lat_day_high <= day_high_byte(cpu_data_in[0],
                                                cpu_data_in[rtc_pkg::day_high_halt_bit],
                                                cpu_data_in[rtc_pkg::day_high_carry_bit]);
               end
               default: ;
            endcase
         end
      end
   end

   // cpu only ever sees the latched set
   always_comb begin
      case (ram_bank)
         rtc_pkg::sel_seconds:  rtc_read_byte = lat_seconds;
         rtc_pkg::sel_minutes:  rtc_read_byte = lat_minutes;
         rtc_pkg::sel_hours:    rtc_read_byte = lat_hours;
         rtc_pkg::sel_day_low:  rtc_read_byte = lat_day_low;
         rtc_pkg::sel_day_high: rtc_read_byte = lat_day_high;
         default:               rtc_read_byte = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- design/rtc_pkg.sv
`default_nettype none

package rtc_pkg;

   typedef logic [7:0] rtc_byte_t;
   typedef logic [8:0] day_count_t;   // day counter 0-511

   // values of the ram bank register that reach the clock
   localparam logic [3:0] sel_seconds  = 4'd8;
   localparam logic [3:0] sel_minutes  = 4'd9;
   localparam logic [3:0] sel_hours    = 4'd10;
   localparam logic [3:0] sel_day_low  = 4'd11;
   localparam logic [3:0] sel_day_high = 4'd12;

   // day high register, bit 0 is the day msb
   localparam int day_high_halt_bit  = 6;
   localparam int day_high_carry_bit = 7;

endpackage

`default_nettype wire

//--- design/save_sequencer.sv
`default_nettype none

module save_sequencer (
   input  wire                   I_CLK_33MHZ,
   input  wire                   I_RESET,
   input  wire                   save,
   input  wire                   load,
   output logic                  copy_active,
   output cart_pkg::ram_addr_t   copy_index,
   output logic                  copy_write,
   output cart_pkg::flash_addr_t flash_addr_save,
   output logic                  flash_oe_n,
   output logic                  flash_we_n,
   output logic                  halt
);

   cart_pkg::save_state_t state;
   logic                  last_index;

   assign last_index = (copy_index == cart_pkg::ram_addr_t'(cart_pkg::ram_bytes - 1));

   // two cycles per byte in both directions
   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         state      <= cart_pkg::idle;
         copy_index <= '0;
      end else begin
         case (state)
            cart_pkg::idle: begin
               copy_index <= '0;
               if (save) begin
                  state <= cart_pkg::write_addr;
               end else if (load) begin
                  state <= cart_pkg::load_addr;
               end
            end
            cart_pkg::write_addr: state <= cart_pkg::write_strobe;
            cart_pkg::write_strobe: begin
               copy_index <= copy_index + 1'b1;
               state <= last_index ? cart_pkg::idle : cart_pkg::write_addr;
            end
            cart_pkg::load_addr: state <= cart_pkg::load_capture;
            cart_pkg::load_capture: begin
               copy_index <= copy_index + 1'b1;
               state <= last_index ? cart_pkg::idle : cart_pkg::load_addr;
            end
            default: state <= cart_pkg::idle;
         endcase
      end
   end

   assign copy_active = (state != cart_pkg::idle);
   assign halt        = copy_active;   // cpu stalled for the whole copy
   assign copy_write  = (state == cart_pkg::load_capture);
   assign flash_we_n  = (state != cart_pkg::write_strobe);
   // flash drives its data pins except while we write it
   assign flash_oe_n  = (state == cart_pkg::write_addr) || (state == cart_pkg::write_strobe);
   assign flash_addr_save = cart_pkg::save_flash_base + cart_pkg::flash_addr_t'(copy_index);

endmodule

`default_nettype wire

//--- verif/cartridge_tb.sv
`default_nettype none

module cartridge_tb;

   localparam int ram_bytes = 32768;
   localparam logic [23:0] save_base = 24'h200000;
   // two copies, then a fill, a clear and a read pass over the ram, plus the short tests
   localparam int cycle_limit = 2 * 2 * ram_bytes + 4 * ram_bytes + 10000;

   logic        I_CLK_33MHZ;
   logic        I_RESET;
   logic [15:0] cpu_addr;
   logic [7:0]  cpu_data_in;
   logic [7:0]  cpu_data_out;
   logic        cpu_we_n;
   logic        cpu_re_n;
   logic        cpu_data_oe;
   logic [23:0] flash_addr;
   logic [15:0] flash_data_in;
   logic [15:0] flash_data_out;
   logic        flash_data_oe;
   logic        flash_oe_n;
   logic        flash_we_n;
   logic        save;
   logic        load;
   logic        halt;

   logic [15:0] flash_mem [logic [23:0]];   // words written by a save
   logic [7:0]  saved_bytes [ram_bytes];
   integer      seed = 32'hfd630a88;
   int          error_count = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          cycle_count = 0;

   tb_clock_gen clock_gen (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET)
   );

   cartridge_top #(
      .ticks_per_second (4)   // short second
   ) UUT (
      .I_CLK_33MHZ    (I_CLK_33MHZ),
      .I_RESET        (I_RESET),
      .cpu_addr       (cpu_addr),
      .cpu_data_in    (cpu_data_in),
      .cpu_we_n       (cpu_we_n),
      .cpu_re_n       (cpu_re_n),
      .cpu_data_out   (cpu_data_out),
      .cpu_data_oe    (cpu_data_oe),
      .flash_addr     (flash_addr),
      .flash_data_in  (flash_data_in),
      .flash_data_out (flash_data_out),
      .flash_data_oe  (flash_data_oe),
      .flash_oe_n     (flash_oe_n),
      .flash_we_n     (flash_we_n),
      .save           (save),
      .load           (load),
      .halt           (halt)
   );

   // low byte mixed with the bank bits and the rest of the address
   function automatic logic [7:0] flash_pattern(input logic [23:0] a);
      return a[7:0] ^ a[21:14] ^ {a[13:8], a[23:22]};
   endfunction

   function automatic logic [31:0] random_word();
      return $random(seed);
   endfunction

   always_comb begin
      if (flash_mem.exists(flash_addr)) begin
         flash_data_in = flash_mem[flash_addr];
      end else begin
         flash_data_in = {8'h00, flash_pattern(flash_addr)};
      end
   end

   always @(negedge I_CLK_33MHZ) begin
      if (flash_we_n === 1'b0) begin
         flash_mem[flash_addr] = flash_data_out;   // mid-cycle, strobe is stable
      end
   end

   always @(posedge I_CLK_33MHZ) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic step();
      @(posedge I_CLK_33MHZ);
      #1;
   endtask

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         $display("Error: time %0t, %s returned 0x%02h, expected 0x%02h", $time, what, got, exp);
         error_count++;
      end
   endtask

   task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
      cpu_addr    = addr;
      cpu_data_in = data;
      cpu_we_n    = 1'b0;
      step();
      cpu_we_n    = 1'b1;
   endtask

   // address held two cycles, covers the registered ram read
   task automatic read_byte(input logic [15:0] addr, output logic [7:0] data);
      cpu_addr = addr;
      cpu_re_n = 1'b0;
      step();
      step();
      data = cpu_data_out;
      assert (cpu_data_oe === 1'b1) else begin
         $display("cpu_data_oe was not driven during a read at time %0t", $time);
         error_count++;
      end
      cpu_re_n = 1'b1;
   endtask

   task automatic expect_read(input logic [15:0] addr, input logic [7:0] exp, input string what);
      logic [7:0] got;
      read_byte(addr, got);
      check_byte(what, got, exp);
   endtask

   task automatic rtc_write(input logic [3:0] sel, input logic [7:0] data);
      write_byte(16'h4000, {4'h0, sel});
      write_byte(16'hA000, data);
   endtask

   task automatic rtc_read(input logic [3:0] sel, output logic [7:0] data);
      write_byte(16'h4000, {4'h0, sel});
      read_byte(16'hA000, data);
   endtask

   task automatic rtc_expect(input logic [3:0] sel, input logic [7:0] exp, input string what);
      logic [7:0] got;
      rtc_read(sel, got);
      check_byte(what, got, exp);
   endtask

   task automatic latch_time();
      write_byte(16'h6000, 8'h00);
      write_byte(16'h6000, 8'h01);
      step();   // pulse, then the copies load
   endtask

   task automatic report_test(input string name, input int start);
      if (error_count == start) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, error_count - start);
      end
   endtask

   task automatic test_reset_state();
      int start;
      start = error_count;
      assert (halt === 1'b0 && flash_we_n === 1'b1 && flash_data_oe === 1'b0
              && cpu_data_oe === 1'b0) else begin
         $display("outputs were not idle after reset at time %0t", $time);
         error_count++;
      end
      report_test("reset state", start);
   endtask

   task automatic test_rom_banking();
      int          start;
      logic [6:0]  banks [5];
      logic [6:0]  used;
      logic [13:0] off;
      start = error_count;
      banks = '{7'd2, 7'h55, 7'h7F, 7'd1, 7'd0};
      expect_read(16'h4042, flash_pattern(24'h004042), "rom bank after reset");
      for (int k = 0; k < 4; k++) begin
         off = 14'(random_word());
         expect_read({2'b00, off}, flash_pattern({10'd0, off}), "rom bank 0");
      end
      for (int b = 0; b < 5; b++) begin
         write_byte(16'h2000, {1'b0, banks[b]});
         used = (banks[b] == 7'd0) ? 7'd1 : banks[b];   // 0 selects 1
         for (int k = 0; k < 4; k++) begin
            off = 14'(random_word());
            expect_read({2'b01, off}, flash_pattern({3'd0, used, off}), "rom upper bank");
         end
         expect_read(16'h0123, flash_pattern(24'h000123), "rom bank 0 after switch");
      end
      report_test("rom banking", start);
   endtask

   task automatic test_ram_banking();
      int          start;
      logic [12:0] offs [8];
      logic [7:0]  data [4][8];
      start = error_count;
      expect_read(16'hA010, 8'h00, "ram after reset");
      write_byte(16'h4000, 8'h00);
      write_byte(16'h0000, 8'h0A);
      write_byte(16'hA010, 8'h33);
      write_byte(16'h0000, 8'h00);
      write_byte(16'hA010, 8'h5A);   // dropped, ram is off
      expect_read(16'hA010, 8'h00, "disabled ram");
      write_byte(16'h0000, 8'h0A);
      expect_read(16'hA010, 8'h33, "ram after write while disabled");
      for (int k = 0; k < 8; k++) begin
         offs[k] = {3'(k), 10'(random_word())};
      end
      for (int b = 0; b < 4; b++) begin
         write_byte(16'h4000, 8'(b));
         for (int k = 0; k < 8; k++) begin
            data[b][k] = 8'(random_word());
            write_byte({3'b101, offs[k]}, data[b][k]);
         end
      end
      // same offsets in every bank, so any overlap shows
      for (int b = 0; b < 4; b++) begin
         write_byte(16'h4000, 8'(b));
         for (int k = 0; k < 8; k++) begin
            expect_read({3'b101, offs[k]}, data[b][k], "ram bank readback");
         end
      end
      report_test("ram enable and banking", start);
   endtask

   task automatic test_rtc_latch();
      int         start;
      logic [7:0] secs;
      start = error_count;
      rtc_write(4'd12, 8'h40);   // stop the clock first
      rtc_write(4'd8, 8'd37);
      rtc_write(4'd9, 8'd12);
      rtc_write(4'd10, 8'd5);
      rtc_write(4'd11, 8'hA3);
      rtc_write(4'd12, 8'h41);
      latch_time();
      rtc_expect(4'd8, 8'd37, "seconds");
      rtc_expect(4'd9, 8'd12, "minutes");
      rtc_expect(4'd10, 8'd5, "hours");
      rtc_expect(4'd11, 8'hA3, "day low");
      rtc_expect(4'd12, 8'h41, "day high");
      rtc_write(4'd12, 8'h01);   // let it run a few seconds
      repeat (16) step();
      rtc_write(4'd12, 8'h41);
      write_byte(16'h6000, 8'h01);
      step();
      rtc_expect(4'd8, 8'd37, "seconds after lone latch write");
      latch_time();
      rtc_read(4'd8, secs);
      assert (secs >= 8'd38 && secs <= 8'd43) else begin
         $display("Error: time %0t, seconds after running read %0d, expected 38 to 43",
                  $time, secs);
         error_count++;
      end
      rtc_expect(4'd9, 8'd12, "minutes after running");
      report_test("clock set and latch", start);
   endtask

   task automatic test_rtc_rollover();
      int         start;
      logic [7:0] secs;
      start = error_count;
      rtc_write(4'd12, 8'h40);
      rtc_write(4'd8, 8'd59);
      rtc_write(4'd9, 8'd59);
      rtc_write(4'd10, 8'd23);
      rtc_write(4'd11, 8'hFF);
      rtc_write(4'd12, 8'h01);   // day 511, running
      repeat (20) step();
      // latched while running, a halt write would also load carry
      latch_time();
      rtc_expect(4'd10, 8'd0, "hours after rollover");
      rtc_expect(4'd9, 8'd0, "minutes after rollover");
      rtc_expect(4'd11, 8'd0, "day low after rollover");
      rtc_expect(4'd12, 8'h80, "day high after rollover");
      rtc_read(4'd8, secs);
      assert (secs >= 8'd2 && secs <= 8'd8) else begin
         $display("Error: time %0t, seconds after rollover read %0d, expected 2 to 8",
                  $time, secs);
         error_count++;
      end
      report_test("clock rollover", start);
   endtask

   task automatic run_copy(input logic do_save, input string what);
      int cycles;
      int bad_dir;
      cycles  = 0;
      bad_dir = 0;
      save    = do_save;
      load    = !do_save;
      step();
      save    = 1'b0;
      load    = 1'b0;
      assert (halt === 1'b1) else begin
         $display("halt did not rise after the %s pulse at time %0t", what, $time);
         error_count++;
      end
      while (halt === 1'b1) begin
         // flash drives the bus only on a load, the cartridge only on a save
         if (flash_oe_n !== do_save || flash_data_oe !== do_save) begin
            bad_dir++;
         end
         load = (cycles == 100);   // stray pulse mid copy
         step();
         cycles++;
      end
      load = 1'b0;
      assert (bad_dir == 0) else begin
         $display("flash bus direction was wrong on %0d cycles of the %s at time %0t",
                  bad_dir, what, $time);
         error_count++;
      end
      assert (cycles == 2 * ram_bytes) else begin
         $display("Error: time %0t, %s held halt for %0d cycles, expected %0d",
                  $time, what, cycles, 2 * ram_bytes);
         error_count++;
      end
   endtask

   task automatic fill_ram(input logic use_random);
      for (int i = 0; i < ram_bytes; i++) begin
         if (i % 8192 == 0) begin
            write_byte(16'h4000, 8'(i / 8192));
         end
         if (use_random) begin
            saved_bytes[i] = 8'(random_word());
            write_byte({3'b101, 13'(i)}, saved_bytes[i]);
         end else begin
            write_byte({3'b101, 13'(i)}, 8'h00);
         end
      end
   endtask

   task automatic test_save_load();
      int          start;
      logic [23:0] fa;
      start = error_count;
      fill_ram(1'b1);
      run_copy(1'b1, "save");
      for (int i = 0; i < ram_bytes; i++) begin
         fa = save_base + 24'(i);
         assert (flash_mem.exists(fa) && flash_mem[fa][7:0] === saved_bytes[i]) else begin
            $display("Error: time %0t, flash word 0x%06h does not hold saved byte 0x%02h",
                     $time, fa, saved_bytes[i]);
            error_count++;
         end
      end
      fill_ram(1'b0);
      run_copy(1'b0, "load");
      for (int i = 0; i < ram_bytes; i++) begin
         if (i % 8192 == 0) begin
            write_byte(16'h4000, 8'(i / 8192));
         end
         expect_read({3'b101, 13'(i)}, saved_bytes[i], "ram after load");
      end
      report_test("save and load", start);
   endtask

   initial begin
      cpu_addr    = '0;
      cpu_data_in = '0;
      cpu_we_n    = 1'b1;
      cpu_re_n    = 1'b1;
      save        = 1'b0;
      load        = 1'b0;
      @(negedge I_RESET);
      step();
      test_reset_state();
      test_rom_banking();
      test_ram_banking();
      test_rtc_latch();
      test_rtc_rollover();
      test_save_load();
      $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
               error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
   output logic I_CLK_33MHZ,
   output logic I_RESET
);

   initial begin
      I_CLK_33MHZ = 1'b0;
      forever #4 I_CLK_33MHZ = ~I_CLK_33MHZ;
   end

   // reset held for 8 rising edges, released just after the last one
   initial begin
      I_RESET = 1'b1;
      repeat (8) @(posedge I_CLK_33MHZ);
      #1 I_RESET = 1'b0;
   end

endmodule

`default_nettype wire
